// ==== project.f ====
+incdir+design
design/up_pkg.sv
design/up_memory.sv
design/up_alu.sv
design/up_control.sv
design/up_top.sv
tests/up_assertions.sv
tests/up_tb.sv

// ==== tests/up_tb.sv ====
`include "up_consts.svh"

module up_tb;

	localparam int NumPrograms = 10;
	localparam int TestCycles  = 2 * 256 + 128 * `UP_INSTR_CYCLES + 20;
	localparam int CycleLimit  = (NumPrograms + 4) * TestCycles + 16;

	// Jump opcodes sit at the end of the table
	localparam up_pkg::opcodeT OpTable [12] = '{
		up_pkg::OP_LDI, up_pkg::OP_LDA, up_pkg::OP_STA, up_pkg::OP_ADD,
		up_pkg::OP_SUB, up_pkg::OP_AND, up_pkg::OP_OR, up_pkg::OP_XOR,
		up_pkg::OP_ADI, up_pkg::OP_JMP, up_pkg::OP_JZ, up_pkg::OP_JC
	};

	// Carry and zero from an ADD wrap, then a SUB borrow
	localparam logic [`UP_DATA_W-1:0] FlagProgram [32] = '{
		up_pkg::OP_LDI, 8'hF0, up_pkg::OP_ADD, 8'hC8, up_pkg::OP_JC, 8'h0A,
		up_pkg::OP_LDI, 8'h11, up_pkg::OP_STA, 8'hD0, up_pkg::OP_JZ, 8'h10,
		up_pkg::OP_LDI, 8'h22, up_pkg::OP_STA, 8'hD1, up_pkg::OP_LDI, 8'h05,
		up_pkg::OP_SUB, 8'hC9, up_pkg::OP_JZ, 8'h18, up_pkg::OP_JC, 8'h1C,
		up_pkg::OP_LDI, 8'h33, up_pkg::OP_STA, 8'hD2, up_pkg::OP_STA, 8'h7F,
		up_pkg::OP_HLT, 8'h00
	};

	logic                  clk;
	logic                  nRst;
	logic                  run;
	logic [`UP_ADDR_W-1:0] loadAddress;
	logic [`UP_DATA_W-1:0] loadData;
	logic                  loadWe;
	logic [`UP_DATA_W-1:0] loadRdData;
	logic                  halted;
	logic [`UP_DATA_W-1:0] test;

	logic [`UP_DATA_W-1:0] model [0:255];

	up_top dut (
		.clk(clk),
		.nRst(nRst),
		.run(run),
		.loadAddress(loadAddress),
		.loadData(loadData),
		.loadWe(loadWe),
		.loadRdData(loadRdData),
		.halted(halted),
		.test(test)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	initial begin
		int cycle;
		for (cycle = 0; cycle < CycleLimit; cycle++)
			@(posedge clk);
		$display("Run hung: no end of test after %0d cycles", CycleLimit);
		$display("*** TEST FAILED ***");
		$fatal(1, "Timeout");
	end

	task automatic checkByte(input string name, input logic [`UP_DATA_W-1:0] expected,
			input logic [`UP_DATA_W-1:0] actual);
		if (actual !== expected) begin
			$display("error %s: expected %02h, actual %02h", name, expected, actual);
			$display("*** TEST FAILED ***");
			$fatal(1, "Byte mismatch");
		end
	endtask

	task automatic checkHalt(input string name, input logic expected, input logic actual);
		if (actual !== expected) begin
			$display("error %s: expected %b, actual %b", name, expected, actual);
			$display("*** TEST FAILED ***");
			$fatal(1, "Halt mismatch");
		end
	endtask

	task automatic checkCount(input string name, input int expected, input int actual);
		if (actual != expected) begin
			$display("error %s: expected %0d, actual %0d", name, expected, actual);
			$display("*** TEST FAILED ***");
			$fatal(1, "Cycle count mismatch");
		end
	endtask

	task automatic writeByte(input logic [`UP_ADDR_W-1:0] address,
			input logic [`UP_DATA_W-1:0] data, input logic we);
		@(posedge clk);
		loadAddress <= address;
		loadData    <= data;
		loadWe      <= we;
	endtask

	task automatic readByte(input logic [`UP_ADDR_W-1:0] address,
			output logic [`UP_DATA_W-1:0] data);
		@(posedge clk);
		loadWe      <= 1'b0;
		loadAddress <= address;
		@(negedge clk); // Combinational read settled
		data = loadRdData;
	endtask

	task automatic loadModel();
		for (int i = 0; i < 256; i++)
			writeByte(i, model[i], 1'b1);
		@(posedge clk);
		loadWe <= 1'b0;
	endtask

	task automatic verifyMemory(input string name);
		logic [`UP_DATA_W-1:0] data;
		for (int i = 0; i < 256; i++) begin
			readByte(i, data);
			checkByte($sformatf("%s mem[%0d]", name, i), model[i], data);
		end
		checkByte({name, " test output"}, model[`UP_TEST_ADDR], test);
	endtask

	// Cycles counted from the restart edge, which starts the first FETCH
	task automatic runProgram(output int count);
		@(posedge clk);
		run <= 1'b1;
		@(posedge clk);
		@(negedge clk);
		checkHalt("run start", 1'b0, halted);
		count = 0;
		do begin
			@(posedge clk);
			count++;
			@(negedge clk);
		end while (!halted);
		@(posedge clk);
		run <= 1'b0;
	endtask

	// ISA reference model working on model[]
	task automatic interpret(output int steps);
		logic [7:0] pc;
		logic [7:0] op;
		logic [7:0] arg;
		logic [7:0] acc;
		logic [8:0] wide;
		logic       zFlag;
		logic       cFlag;
		bit         update;
		pc    = 8'h00;
		acc   = 8'h00;
		zFlag = 1'b0;
		cFlag = 1'b0;
		op    = 8'h00;
		steps = 0;
		while (op != up_pkg::OP_HLT && steps < 1000) begin
			op     = model[pc];
			arg    = model[pc + 8'd1];
			pc     = pc + 8'd2;
			update = 1'b1;
			steps++;
			case (op)
				up_pkg::OP_LDI: wide = {1'b0, arg};
				up_pkg::OP_LDA: wide = {1'b0, model[arg]};
				up_pkg::OP_ADD: wide = {1'b0, acc} + {1'b0, model[arg]};
				up_pkg::OP_SUB: wide = {acc < model[arg], acc - model[arg]}; // Borrow on top
				up_pkg::OP_AND: wide = {1'b0, acc & model[arg]};
				up_pkg::OP_OR:  wide = {1'b0, acc | model[arg]};
				up_pkg::OP_XOR: wide = {1'b0, acc ^ model[arg]};
				up_pkg::OP_ADI: wide = {1'b0, acc} + {1'b0, arg};
				default: begin
					update = 1'b0;
					if (op == up_pkg::OP_STA)
						model[arg] = acc;
					if (op == up_pkg::OP_JMP || (op == up_pkg::OP_JZ && zFlag) ||
							(op == up_pkg::OP_JC && cFlag))
						pc = arg;
				end
			endcase
			if (update) begin
				acc   = wide[7:0];
				cFlag = wide[8];
				zFlag = (acc == 8'h00);
			end
		end
	endtask

	// Data in the upper half and forward-only jumps
	task automatic buildProgram(input bit jumps, output int length);
		int             body;
		up_pkg::opcodeT op;
		logic [7:0]     arg;
		body = $urandom_range(40, 1);
		for (int i = 0; i < 256; i++)
			model[i] = (i < 128) ? 8'h00 : 8'($urandom);
		for (int i = 0; i < body; i++) begin
			op = OpTable[$urandom_range(jumps ? 11 : 8, 0)];
			case (op)
				up_pkg::OP_LDI, up_pkg::OP_ADI: arg = 8'($urandom);
				up_pkg::OP_JMP, up_pkg::OP_JZ, up_pkg::OP_JC:
					arg = 8'(2 * $urandom_range(body, i + 1));
				default: arg = 8'(128 + $urandom_range(127, 0));
			endcase
			model[2 * i]     = op;
			model[2 * i + 1] = arg;
		end
		model[2 * body]     = up_pkg::OP_STA;
		model[2 * body + 1] = `UP_TEST_ADDR;
		model[2 * body + 2] = up_pkg::OP_HLT;
		length = body + 2;
	endtask

	// A nonzero length fixes the instruction count
	task automatic execute(input string name, input int length);
		int steps;
		int count;
		interpret(steps);
		runProgram(count);
		checkCount({name, " cycles"}, (length > 0 ? length : steps) * `UP_INSTR_CYCLES, count);
		checkHalt({name, " halted"}, 1'b1, halted);
		verifyMemory(name);
	endtask

	initial begin
		logic [`UP_ADDR_W-1:0] address;
		int                    length;
		void'($urandom(68));
		nRst        = 1'b0;
		run         = 1'b0;
		loadAddress = '0;
		loadData    = '0;
		loadWe      = 1'b0;
		repeat (16) @(posedge clk);
		nRst <= 1'b1;
		@(negedge clk);

		for (int i = 0; i < 256; i++)
			model[i] = (i < `UP_BOOT_LEN) ? up_pkg::bootImage[i] : 8'h00;
		checkHalt("reset halted", 1'b1, halted);
		checkByte("reset test output", model[`UP_TEST_ADDR], test);
		verifyMemory("reset");
		execute("boot run", 0);

		for (int i = 0; i < 32; i++) begin
			address        = $urandom;
			model[address] = $urandom;
			writeByte(address, model[address], 1'b1);
		end
		for (int i = 0; i < 16; i++)
			writeByte($urandom, $urandom, 1'b0); // Memory untouched with loadWe low
		verifyMemory("loader");

		for (int p = 0; p < NumPrograms; p++) begin
			buildProgram(1'b1, length);
			loadModel();
			execute($sformatf("program %0d", p), 0);
		end

		buildProgram(1'b0, length);
		loadModel();
		execute("straight line", length);

		for (int i = 0; i < 256; i++)
			model[i] = (i < 32) ? FlagProgram[i] : 8'h00;
		model[8'hC8] = 8'h10;
		model[8'hC9] = 8'h07;
		loadModel();
		execute("flags", 0);

		if (dut.control.checks.errorCount == 0) begin
			$display("*** TEST PASSED ***");
			$finish;
		end else begin
			$display("Assertions failed %0d times", dut.control.checks.errorCount);
			$display("*** TEST FAILED ***");
			$fatal(1, "Assertion failures");
		end
	end

endmodule

// ==== tests/up_assertions.sv ====
`include "up_consts.svh"

module up_assertions (
	input logic                  clk,
	input logic                  nRst,
	input logic                  run,
	input logic                  runPrev,
	input up_pkg::stateT         state,
	input logic [`UP_ADDR_W-1:0] pc,
	input logic                  memWe,
	input logic                  loadWe
);

	int errorCount = 0;

	// Stores only happen in EXECUTE
	noEarlyStore: assert property (@(posedge clk) disable iff (!nRst)
		(run && (state == up_pkg::FETCH || state == up_pkg::OPERAND)) |-> !memWe)
		else begin
			$error("memWe high in FETCH or OPERAND");
			errorCount++;
		end

	haltHolds: assert property (@(posedge clk) disable iff (!nRst)
		(run && runPrev && state == up_pkg::HALT) |=> state == up_pkg::HALT)
		else begin
			$error("sequencer left HALT while run stayed high");
			errorCount++;
		end

	pcStep: assert property (@(posedge clk) disable iff (!nRst)
		(run && runPrev && state == up_pkg::OPERAND) |=> pc == $past(pc) + `UP_ADDR_W'(2))
		else begin
			$error("program counter did not step by 2 after OPERAND");
			errorCount++;
		end

	// Jumps land only out of EXECUTE
	pcQuiet: assert property (@(posedge clk) disable iff (!nRst)
		(run && runPrev && !(state inside {up_pkg::OPERAND, up_pkg::EXECUTE})) |=> $stable(pc))
		else begin
			$error("program counter moved outside OPERAND and EXECUTE");
			errorCount++;
		end

	loaderWrite: assert property (@(posedge clk) disable iff (!nRst)
		!run |-> memWe == loadWe)
		else begin
			$error("memWe does not follow loadWe while run is low");
			errorCount++;
		end

endmodule

bind up_control up_assertions checks (
	.clk(clk),
	.nRst(nRst),
	.run(run),
	.runPrev(runPrev),
	.state(state),
	.pc(pc),
	.memWe(memWe),
	.loadWe(loadWe)
);

// ==== design/up_top.sv ====
`include "up_consts.svh"

module up_top (
	input  logic                  clk,
	input  logic                  nRst,
	input  logic                  run,
	input  logic [`UP_ADDR_W-1:0] loadAddress,
	input  logic [`UP_DATA_W-1:0] loadData,
	input  logic                  loadWe,
	output logic [`UP_DATA_W-1:0] loadRdData,
	output logic                  halted,
	output logic [`UP_DATA_W-1:0] test
);

	logic [`UP_ADDR_W-1:0] memAddress;
	logic [`UP_DATA_W-1:0] memWrData;
	logic [`UP_DATA_W-1:0] memRdData;
	logic                  memWe;

	logic [`UP_DATA_W-1:0] aluA;
	logic [`UP_DATA_W-1:0] aluB;
	logic [`UP_DATA_W-1:0] aluResult;
	logic                  aluZero;
	logic                  aluCarry;
	up_pkg::aluOpT         aluOp;

	up_control control (
		.clk(clk),
		.nRst(nRst),
		.run(run),
		.loadAddress(loadAddress),
		.loadData(loadData),
		.loadWe(loadWe),
		.memRdData(memRdData),
		.aluResult(aluResult),
		.aluZero(aluZero),
		.aluCarry(aluCarry),
		.memAddress(memAddress),
		.memWrData(memWrData),
		.memWe(memWe),
		.aluA(aluA),
		.aluB(aluB),
		.aluOp(aluOp),
		.loadRdData(loadRdData),
		.halted(halted)
	);

	up_alu alu (
		.a(aluA),
		.b(aluB),
		.op(aluOp),
		.result(aluResult),
		.zero(aluZero),
		.carry(aluCarry)
	);

	up_memory memory (
		.clk(clk),
		.nRst(nRst),
		.address(memAddress),
		.in(memWrData),
		.we(memWe),
		.out(memRdData),
		.test(test)
	);

endmodule

// ==== design/up_control.sv ====
`include "up_consts.svh"

module up_control (
	input  logic                  clk,
	input  logic                  nRst,
	input  logic                  run,
	input  logic [`UP_ADDR_W-1:0] loadAddress,
	input  logic [`UP_DATA_W-1:0] loadData,
	input  logic                  loadWe,
	input  logic [`UP_DATA_W-1:0] memRdData,
	input  logic [`UP_DATA_W-1:0] aluResult,
	input  logic                  aluZero,
	input  logic                  aluCarry,
	output logic [`UP_ADDR_W-1:0] memAddress,
	output logic [`UP_DATA_W-1:0] memWrData,
	output logic                  memWe,
	output logic [`UP_DATA_W-1:0] aluA,
	output logic [`UP_DATA_W-1:0] aluB,
	output up_pkg::aluOpT         aluOp,
	output logic [`UP_DATA_W-1:0] loadRdData,
	output logic                  halted
);

	up_pkg::stateT state;

	logic [`UP_ADDR_W-1:0] pc;
	logic [`UP_DATA_W-1:0] ir;
	logic [`UP_DATA_W-1:0] operand;
	logic [`UP_DATA_W-1:0] acc;
	logic                  zFlag;
	logic                  cFlag;
	logic                  runPrev;

	logic runRise;
	logic active;
	logic useImm;
	logic accWe;
	logic storeOp;
	logic haltOp;
	logic jumpTaken;

	assign runRise = run & ~runPrev;
	assign active  = run & runPrev; // Restart cycle excluded

	// Unknown opcodes decode as NOP
	always_comb begin
		aluOp     = up_pkg::ALU_PASS;
		useImm    = 1'b0;
		accWe     = 1'b0;
		storeOp   = 1'b0;
		haltOp    = 1'b0;
		jumpTaken = 1'b0;
		case (ir)
			up_pkg::OP_HLT: haltOp = 1'b1;
			up_pkg::OP_LDI: begin
				useImm = 1'b1;
				accWe  = 1'b1;
			end
			up_pkg::OP_LDA: accWe = 1'b1;
			up_pkg::OP_STA: storeOp = 1'b1;
			up_pkg::OP_ADD: begin
				aluOp = up_pkg::ALU_ADD;
				accWe = 1'b1;
			end
			up_pkg::OP_SUB: begin
				aluOp = up_pkg::ALU_SUB;
				accWe = 1'b1;
			end
			up_pkg::OP_AND: begin
				aluOp = up_pkg::ALU_AND;
				accWe = 1'b1;
			end
			up_pkg::OP_OR: begin
				aluOp = up_pkg::ALU_OR;
				accWe = 1'b1;
			end
			up_pkg::OP_XOR: begin
				aluOp = up_pkg::ALU_XOR;
				accWe = 1'b1;
			end
			up_pkg::OP_ADI: begin
				aluOp  = up_pkg::ALU_ADD;
				useImm = 1'b1;
				accWe  = 1'b1;
			end
			up_pkg::OP_JMP: jumpTaken = 1'b1;
			up_pkg::OP_JZ:  jumpTaken = zFlag;
			up_pkg::OP_JC:  jumpTaken = cFlag;
			default: ;
		endcase
	end

	assign aluA = acc;
	assign aluB = useImm ? operand : memRdData;

	// Loader owns the memory while run is low
	always_comb begin
		if (!run) begin
			memAddress = loadAddress;
		end else begin
			case (state)
				up_pkg::FETCH:   memAddress = pc;
				up_pkg::OPERAND: memAddress = pc + `UP_ADDR_W'(1);
				up_pkg::EXECUTE: memAddress = operand;
				default:         memAddress = pc;
			endcase
		end
	end

	assign memWrData  = run ? acc : loadData;
	assign memWe      = run ? (active && state == up_pkg::EXECUTE && storeOp) : loadWe;
	assign loadRdData = memRdData;
	assign halted     = (state == up_pkg::HALT);

	always_ff @(posedge clk or negedge nRst) begin
		if (!nRst) begin
			state   <= up_pkg::HALT;
			pc      <= '0;
			ir      <= '0;
			operand <= '0;
			acc     <= '0;
			zFlag   <= 1'b0;
			cFlag   <= 1'b0;
			runPrev <= 1'b0;
		end else begin
			runPrev <= run;
			if (runRise) begin
				state <= up_pkg::FETCH;
				pc    <= '0;
				acc   <= '0;
				zFlag <= 1'b0;
				cFlag <= 1'b0;
			end else if (active) begin
				case (state)
					up_pkg::FETCH: begin
						ir    <= memRdData;
						state <= up_pkg::OPERAND;
					end
					up_pkg::OPERAND: begin
						operand <= memRdData;
						pc      <= pc + `UP_ADDR_W'(2);
						state   <= up_pkg::EXECUTE;
					end
					up_pkg::EXECUTE: begin
						if (accWe) begin
							acc   <= aluResult;
							zFlag <= aluZero;
							cFlag <= aluCarry;
						end
						if (jumpTaken)
							pc <= operand;
						state <= haltOp ? up_pkg::HALT : up_pkg::FETCH;
					end
					default: ; // Parked until run drops
				endcase
			end
		end
	end

endmodule

// ==== design/up_alu.sv ====
`include "up_consts.svh"

module up_alu (
	input  logic [`UP_DATA_W-1:0] a,
	input  logic [`UP_DATA_W-1:0] b,
	input  up_pkg::aluOpT         op,
	output logic [`UP_DATA_W-1:0] result,
	output logic                  zero,
	output logic                  carry
);

	// One spare bit on top for carry or borrow
	logic [`UP_DATA_W:0] wide;

	always_comb begin
		case (op)
			up_pkg::ALU_ADD: begin
				wide = {1'b0, a} + {1'b0, b};
			end
			up_pkg::ALU_SUB: begin
				wide = {1'b0, a} - {1'b0, b}; // Top bit is the borrow
			end
			up_pkg::ALU_AND: begin
				wide = {1'b0, a & b};
			end
			up_pkg::ALU_OR: begin
				wide = {1'b0, a | b};
			end
			up_pkg::ALU_XOR: begin
				wide = {1'b0, a ^ b};
			end
			default: begin
				wide = {1'b0, b}; // Pass operand through for loads
			end
		endcase
	end

	assign result = wide[`UP_DATA_W-1:0];
	assign carry  = wide[`UP_DATA_W];
	assign zero   = (result == '0);

endmodule

// ==== design/up_memory.sv ====
`include "up_consts.svh"

module up_memory (
	input  logic                  clk,
	input  logic                  nRst,
	input  logic [`UP_ADDR_W-1:0] address,
	input  logic [`UP_DATA_W-1:0] in,
	input  logic                  we,
	output logic [`UP_DATA_W-1:0] out,
	output logic [`UP_DATA_W-1:0] test
);

	localparam int Depth = 2 ** `UP_ADDR_W;

	logic [`UP_DATA_W-1:0] mem [0:Depth-1];

	assign out  = mem[address];
	assign test = mem[`UP_TEST_ADDR];

	// Boot program in the low bytes and zero above it
	always_ff @(posedge clk or negedge nRst) begin
		if (!nRst) begin
			for (int i = 0; i < Depth; i++) begin
				if (i < `UP_BOOT_LEN)
					mem[i] <= up_pkg::bootImage[i];
				else
					mem[i] <= '0;
			end
		end else if (we) begin
			mem[address] <= in;
		end
	end

endmodule

// ==== design/up_pkg.sv ====
`include "up_consts.svh"

package up_pkg;

	// Every instruction is an opcode byte followed by an operand byte
	typedef enum logic [`UP_DATA_W-1:0] {
		OP_NOP = 8'h00,
		OP_HLT = 8'h01,
		OP_LDI = 8'h10, // acc = imm
		OP_LDA = 8'h11, // acc = mem[addr]
		OP_STA = 8'h12, // mem[addr] = acc
		OP_ADD = 8'h20,
		OP_SUB = 8'h21,
		OP_AND = 8'h22,
		OP_OR  = 8'h23,
		OP_XOR = 8'h24,
		OP_ADI = 8'h25, // acc += imm
		OP_JMP = 8'h30,
		OP_JZ  = 8'h31,
		OP_JC  = 8'h32
	} opcodeT;

	typedef enum logic [1:0] {
		FETCH,
		OPERAND,
		EXECUTE,
		HALT
	} stateT;

	typedef enum logic [2:0] {
		ALU_PASS,
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR
	} aluOpT;

	// Sums the six bytes at 18..23 and leaves the total at the test address
	parameter logic [`UP_DATA_W-1:0] bootImage [0:`UP_BOOT_LEN-1] = '{
		8'h11, 8'd18,
		8'h20, 8'd19,
		8'h20, 8'd20,
		8'h20, 8'd21,
		8'h20, 8'd22,
		8'h20, 8'd23,
		8'h12, 8'd127,
		8'h01, 8'h00,
		8'h00, 8'h00, // spare
		8'h5B, 8'h46, 8'h96, 8'h76, 8'hAA, 8'h54
	};

endpackage

// ==== design/up_consts.svh ====
`ifndef UP_CONSTS_SVH
`define UP_CONSTS_SVH

// Datapath widths
`define UP_DATA_W 8
`define UP_ADDR_W 8

// Memory cell mirrored on the test output
`define UP_TEST_ADDR 127

// Bytes of the boot image loaded at reset
`define UP_BOOT_LEN 24

// Fetch, operand and execute
`define UP_INSTR_CYCLES 3

`endif
